// File: vsetup_input.txt
# Q ax ay bx by cx cy dx dy drx dry : one quad, decimal, corners A B C D
# E idx lx ly rx ry : expected left (A-C) and right (A-D) point of a line of the quad above
Q 10 20 100 20 40 60 130 90 90 4
E 0 10 20 10 20
E 1 17 30 40 37
E 2 25 40 70 55
E 3 32 50 100 72
Q 0 0 -50 5 -37 -11 23 -100 77 3
E 0 0 0 0 0
E 1 -12 -3 7 -33
E 2 -24 -7 15 -66
Q -1000 500 5 6 2000 -3000 -65000 65000 1 1
E 0 -1000 500 -1000 500
Q 100 -100 0 0 100 -100 47 -93 4095 5
E 0 100 -100 100 -100
E 1 100 -100 90 -99
E 2 100 -100 79 -98
E 3 100 -100 69 -96
E 4 100 -100 58 -95
Q 1000 -2000 7 8 66535 -6094 -130071 2095 2048 4095
E 1 1016 -2000 968 -1999
E 2048 33775 -4047 -64551 48
E 4094 66518 -6093 -130038 2094
Q 5 5 1 2 8 -5 -5 9 3 2
E 0 5 5 5 5
E 1 6 0 0 7
Q 10 20 100 20 40 60 130 90 90 4
E 1 17 30 40 37
E 3 32 50 100 72

// File: project.f
tmu_vsetup_pkg.sv
tmu_vdivops.sv
tmu_vdiv.sv
tmu_vinterp.sv
tmu_vsetup.sv
tb_tmu_vsetup.sv

// File: Bender.yml
package:
  name: tmu_vsetup

sources:
  - tmu_vsetup_pkg.sv
  - tmu_vdivops.sv
  - tmu_vdiv.sv
  - tmu_vinterp.sv
  - tmu_vsetup.sv
  - target: test
    files:
      - tb_tmu_vsetup.sv

// File: tb_tmu_vsetup.sv
/*
 * Testbench for the vertical setup pipeline, reads quads and expected lines
 * from vsetup_input.txt in the project root. Ack stalls and quad gaps are random.
 * Every line is also checked against floor(|diff|*i/dry) on each edge component.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_tmu_vsetup;

	typedef struct packed {
		int ax, ay, bx, by, cx, cy, dx, dy, drx, dry;
	} quad_rec_t;

	typedef struct packed {
		int q, idx, lx, ly, rx, ry; // Quad number and line index it belongs to.
	} exp_rec_t;

	logic                  sys_clk;
	logic                  sys_rst;
	logic                  quad_stb_i;
	logic                  quad_ack_o;
	tmu_vsetup_pkg::quad_t quad_i;
	logic                  line_stb_o;
	logic                  line_ack_i;
	tmu_vsetup_pkg::line_t line_o;

	quad_rec_t             quads[$];
	exp_rec_t              exps[$];
	int                    errors, total_lines, lines_seen, cur_q, cur_idx;
	bit                    loaded, quad_sent, held_valid, rst_seen;
	tmu_vsetup_pkg::line_t held_line; // Line seen while stalled.
	longint                limit_ns;

	tmu_vsetup i_dut (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.quad_stb_i (quad_stb_i),
		.quad_ack_o (quad_ack_o),
		.quad_i     (quad_i),
		.line_stb_o (line_stb_o),
		.line_ack_i (line_ack_i),
		.line_o     (line_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// Point on the edge from a to e at line i of dry.
	function automatic int edge_point(input int a, input int e, input int dry, input int i);
		longint off;
		off = (longint'(e > a ? e - a : a - e) * i) / dry; // Floor, all positive.
		return (e > a) ? a + int'(off) : a - int'(off);
	endfunction

	task automatic compare_field(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("Mismatch %s: got %h, expected %h (quad %0d line %0d)",
				name, got, exp, cur_q, cur_idx);
			errors++;
		end
	endtask

	// Hold the quad until the DUT takes it.
	task automatic send_quad(input quad_rec_t r);
		quad_i.a.x = 18'(r.ax);
		quad_i.a.y = 18'(r.ay);
		quad_i.b.x = 18'(r.bx);
		quad_i.b.y = 18'(r.by);
		quad_i.c.x = 18'(r.cx);
		quad_i.c.y = 18'(r.cy);
		quad_i.d.x = 18'(r.dx);
		quad_i.d.y = 18'(r.dy);
		quad_i.drx = 12'(r.drx);
		quad_i.dry = 12'(r.dry);
		quad_stb_i = 1'b1;
		quad_sent  = 1'b1;
		do @(posedge sys_clk); while (!quad_ack_o);
		@(negedge sys_clk);
		quad_stb_i = 1'b0;
	endtask

	// Random back-pressure on the output.
	initial begin
		wait (loaded);
		forever @(negedge sys_clk) line_ack_i = ($urandom_range(3) != 0);
	end

	// Output monitor sampling before the DUT registers update.
	always @(posedge sys_clk) begin
		// Registers only settle at the first edge under reset.
		if (!quad_sent && rst_seen) begin
			assert (!line_stb_o) else begin
				$display("Line strobe high before any quad was supplied.");
				errors++;
			end
		end
		if (sys_rst) begin
			rst_seen = 1'b1;
		end
		if (!sys_rst && held_valid) begin
			assert (line_stb_o && line_o === held_line) else begin
				$display("Output line changed or dropped while stalled.");
				errors++;
			end
		end
		held_valid = !sys_rst && line_stb_o && !line_ack_i;
		held_line  = line_o;
		if (!sys_rst && line_stb_o && line_ack_i) begin
			if (cur_q >= quads.size()) begin
				$display("Extra line accepted after all quads were done.");
				errors++;
			end else begin
				compare_field("line_o.idx", int'(line_o.idx), cur_idx);
				compare_field("line_o.last", int'(line_o.last),
					int'(cur_idx == quads[cur_q].dry - 1));
				compare_field("line_o.b.x", int'($signed(line_o.b.x)), quads[cur_q].bx);
				compare_field("line_o.b.y", int'($signed(line_o.b.y)), quads[cur_q].by);
				compare_field("line_o.drx", int'(line_o.drx), quads[cur_q].drx);
				compare_field("line_o.left.x", int'($signed(line_o.left.x)),
					edge_point(quads[cur_q].ax, quads[cur_q].cx, quads[cur_q].dry, cur_idx));
				compare_field("line_o.left.y", int'($signed(line_o.left.y)),
					edge_point(quads[cur_q].ay, quads[cur_q].cy, quads[cur_q].dry, cur_idx));
				compare_field("line_o.right.x", int'($signed(line_o.right.x)),
					edge_point(quads[cur_q].ax, quads[cur_q].dx, quads[cur_q].dry, cur_idx));
				compare_field("line_o.right.y", int'($signed(line_o.right.y)),
					edge_point(quads[cur_q].ay, quads[cur_q].dy, quads[cur_q].dry, cur_idx));
				// Listed points from the data file.
				if (exps.size() > 0 && exps[0].q == cur_q && exps[0].idx == cur_idx) begin
					compare_field("line_o.left.x", int'($signed(line_o.left.x)), exps[0].lx);
					compare_field("line_o.left.y", int'($signed(line_o.left.y)), exps[0].ly);
					compare_field("line_o.right.x", int'($signed(line_o.right.x)), exps[0].rx);
					compare_field("line_o.right.y", int'($signed(line_o.right.y)), exps[0].ry);
					void'(exps.pop_front());
				end
				cur_idx++;
				if (cur_idx == quads[cur_q].dry) begin
					cur_q++;
					cur_idx = 0;
				end
			end
			lines_seen++;
		end
	end

	initial begin
		wait (loaded);
		#(limit_ns);
		$display("Timeout after %0d ns, %0d of %0d lines seen.", limit_ns, lines_seen,
			total_lines);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		int        fd, n, gap;
		string     line;
		quad_rec_t r;
		exp_rec_t  e;
		sys_rst    = 1'b1;
		quad_stb_i = 1'b0;
		quad_i     = '0;
		line_ack_i = 1'b0;
		errors     = 0;
		void'($urandom(32'hac08));
		fd         = $fopen("vsetup_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the data file vsetup_input.txt.");
			$display("FAIL: see errors above");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line[0] == "#") continue; // Blank or comment.
				if (line[0] == "Q") begin
					n = $sscanf(line, "Q %d %d %d %d %d %d %d %d %d %d", r.ax, r.ay,
						r.bx, r.by, r.cx, r.cy, r.dx, r.dy, r.drx, r.dry);
					if (n != 10) begin
						$display("Malformed quad record in the data file.");
						errors++;
					end else begin
						quads.push_back(r);
						total_lines += r.dry;
					end
				end else if (line[0] == "E") begin
					n = $sscanf(line, "E %d %d %d %d %d", e.idx, e.lx, e.ly, e.rx, e.ry);
					e.q = quads.size() - 1;
					if (n != 5) begin
						$display("Malformed expected line record in the data file.");
						errors++;
					end else begin
						exps.push_back(e);
					end
				end
			end
			$fclose(fd);
			foreach (quads[k]) limit_ns += longint'(quads[k].dry + 40) * 20;
			limit_ns = 2 * limit_ns + 2000; // Stalls take about a quarter of the cycles.
			loaded   = 1'b1;
			repeat (8) @(posedge sys_clk);
			@(negedge sys_clk);
			sys_rst = 1'b0;
			repeat (3) @(negedge sys_clk); // Output must stay idle meanwhile.
			foreach (quads[k]) begin
				gap = ($urandom_range(1) == 0) ? 0 : $urandom_range(6, 1);
				repeat (gap) @(negedge sys_clk);
				send_quad(quads[k]);
			end
			wait (lines_seen >= total_lines);
			repeat (5) @(posedge sys_clk);
			assert (!line_stb_o) else begin
				$display("Line strobe still high after the last line.");
				errors++;
			end
			assert (exps.size() == 0) else begin
				$display("%0d listed lines from the data file were never seen.", exps.size());
				errors++;
			end
			$display("Errors: %0d, lines seen: %0d of %0d", errors, lines_seen, total_lines);
			if (errors == 0) begin
				$display("PASS: all tests");
			end else begin
				$display("FAIL: see errors above");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tmu_vsetup.sv
/*
 * Vertical setup of the texture mapping unit.
 * Difference, divide and edge-step stages chained by stb/ack links.
 * First line appears at least 20 cycles after a quad is accepted.
 */
`timescale 1ns/1ps
`default_nettype none

module tmu_vsetup (
	input  wire                        sys_clk,
	input  wire                        sys_rst,

	input  wire                        quad_stb_i,
	output logic                       quad_ack_o,
	input  wire tmu_vsetup_pkg::quad_t quad_i,

	output logic                       line_stb_o,
	input  wire                        line_ack_i,
	output tmu_vsetup_pkg::line_t      line_o
);

	logic                     ops_stb;
	logic                     ops_ack;
	tmu_vsetup_pkg::diffops_t ops;     // Deltas as magnitude and direction.
	logic                     div_stb;
	logic                     div_ack;
	tmu_vsetup_pkg::divres_t  div;     // Quotients and remainders by dry.

	tmu_vdivops u_vdivops (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.pipe_stb_i (quad_stb_i),
		.pipe_ack_o (quad_ack_o),
		.quad_i     (quad_i),
		.pipe_stb_o (ops_stb),
		.pipe_ack_i (ops_ack),
		.ops_o      (ops)
	);

	tmu_vdiv u_vdiv (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.pipe_stb_i (ops_stb),
		.pipe_ack_o (ops_ack),
		.ops_i      (ops),
		.pipe_stb_o (div_stb),
		.pipe_ack_i (div_ack),
		.div_o      (div)
	);

	tmu_vinterp u_vinterp (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.pipe_stb_i (div_stb),
		.pipe_ack_o (div_ack),
		.div_i      (div),
		.pipe_stb_o (line_stb_o),
		.pipe_ack_i (line_ack_i),
		.line_o     (line_o)
	);

endmodule

`default_nettype wire

// File: tmu_vinterp.sv
/*
 * Vertical edge stepper. Emits dry lines per quad, integer part only.
 * Offset on line i is floor(|diff|*i/dry), built from quotient, remainder and error term.
 * Holding ack low freezes the current line.
 */
`timescale 1ns/1ps
`default_nettype none

module tmu_vinterp (
	input  wire                          sys_clk,
	input  wire                          sys_rst,

	input  wire                          pipe_stb_i,
	output logic                         pipe_ack_o,
	input  wire tmu_vsetup_pkg::divres_t div_i,

	output logic                         pipe_stb_o,
	input  wire                          pipe_ack_i,
	output tmu_vsetup_pkg::line_t        line_o
);

	localparam int CW = tmu_vsetup_pkg::COORD_W;
	localparam int DW = tmu_vsetup_pkg::DIFF_W;
	localparam int RW = tmu_vsetup_pkg::RES_W;

	logic                    accept;
	logic                    advance;
	tmu_vsetup_pkg::divres_t div_q;
	logic [RW-1:0]           idx_q;
	logic [RW-1:0]           idx_nx;
	logic                    last_q;
	logic [DW-1:0]           off_q [4]; // Running offsets from A.
	logic [RW-1:0]           err_q [4]; // Error terms, always below dry.
	logic [DW-1:0]           off_d [4];
	logic [RW-1:0]           err_d [4];
	logic [DW-1:0]           quo   [4];
	logic [RW-1:0]           rem   [4];
	logic                    pos   [4];
	logic signed [CW-1:0]    base  [4];
	logic signed [CW-1:0]    pt    [4];

	assign pipe_ack_o = !pipe_stb_o; // Idle only.
	assign accept     = pipe_stb_i && pipe_ack_o;
	assign advance    = pipe_stb_o && pipe_ack_i && !last_q;
	assign idx_nx     = idx_q + 1'b1;

	// Edge order is cx, cy, dx, dy.
	always_comb begin
		quo[0]  = div_q.dcx.quo;
		quo[1]  = div_q.dcy.quo;
		quo[2]  = div_q.ddx.quo;
		quo[3]  = div_q.ddy.quo;
		rem[0]  = div_q.dcx.rem;
		rem[1]  = div_q.dcy.rem;
		rem[2]  = div_q.ddx.rem;
		rem[3]  = div_q.ddy.rem;
		pos[0]  = div_q.dcx.pos;
		pos[1]  = div_q.dcy.pos;
		pos[2]  = div_q.ddx.pos;
		pos[3]  = div_q.ddy.pos;
		base[0] = div_q.a.x;
		base[1] = div_q.a.y;
		base[2] = div_q.a.x;
		base[3] = div_q.a.y;
	end

	// Next offsets and current points.
	always_comb begin
		logic [RW:0] acc;
		for (int k = 0; k < 4; k++) begin
			acc = {1'b0, err_q[k]} + {1'b0, rem[k]}; // Below 2*dry.
			if (acc >= {1'b0, div_q.dry}) begin
				acc      = acc - {1'b0, div_q.dry};
				off_d[k] = off_q[k] + quo[k] + 1'b1; // Carry from error term.
			end else begin
				off_d[k] = off_q[k] + quo[k];
			end
			err_d[k] = acc[RW-1:0];
			if (pos[k]) begin
				pt[k] = base[k] + $signed({1'b0, off_q[k]});
			end else begin
				pt[k] = base[k] - $signed({1'b0, off_q[k]});
			end
		end
	end

	// Line control.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pipe_stb_o <= 1'b0;
			idx_q      <= '0;
			last_q     <= 1'b0;
		end else if (accept) begin
			pipe_stb_o <= 1'b1; // Line 0 next cycle.
			idx_q      <= '0;
			last_q     <= (div_i.dry == RW'(1));
		end else if (advance) begin
			idx_q  <= idx_nx;
			last_q <= (idx_nx == div_q.dry - 1'b1);
		end else if (pipe_stb_o && pipe_ack_i) begin
			pipe_stb_o <= 1'b0; // Last line taken.
		end
	end

	// Edge state.
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			div_q <= div_i;
			for (int k = 0; k < 4; k++) begin
				off_q[k] <= '0;
				err_q[k] <= '0;
			end
		end else if (advance) begin
			for (int k = 0; k < 4; k++) begin
				off_q[k] <= off_d[k];
				err_q[k] <= err_d[k];
			end
		end
	end

	always_comb begin
		line_o.idx     = idx_q;
		line_o.last    = last_q;
		line_o.left.x  = pt[0];
		line_o.left.y  = pt[1];
		line_o.right.x = pt[2];
		line_o.right.y = pt[3];
		line_o.b       = div_q.b;
		line_o.drx     = div_q.drx;
	end

	// Registered last flag must agree with the line count.
	a_last_idx: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_o |-> (line_o.last == (line_o.idx == div_q.dry - 1'b1)))
		else $error("tmu_vinterp: last flag out of step with line index.");

endmodule

`default_nettype wire

// File: tmu_vdiv.sv
/*
 * Divider stage. Four restoring dividers, one quotient bit per cycle.
 * Result is valid 18 cycles after acceptance, one quad at a time.
 * dry must be nonzero. Flags and context pass through untouched.
 */
`timescale 1ns/1ps
`default_nettype none

module tmu_vdiv (
	input  wire                           sys_clk,
	input  wire                           sys_rst,

	input  wire                           pipe_stb_i,
	output logic                          pipe_ack_o,
	input  wire tmu_vsetup_pkg::diffops_t ops_i,

	output logic                          pipe_stb_o,
	input  wire                           pipe_ack_i,
	output tmu_vsetup_pkg::divres_t       div_o
);

	localparam int DW    = tmu_vsetup_pkg::DIFF_W;
	localparam int RW    = tmu_vsetup_pkg::RES_W;
	localparam int STEPS = DW; // One step per dividend bit.

	logic                     accept;
	logic                     running_q;  // Division in progress.
	logic [4:0]               step_q;     // Steps done so far.
	logic                     steps_done;
	tmu_vsetup_pkg::diffops_t ctx_q;      // Flags and context of the quad.
	logic [DW-1:0]            dvd_q [4];  // Dividend shifting out, quotient in.
	logic [RW-1:0]            rem_q [4];  // Partial remainder.
	logic [DW-1:0]            dvd_d [4];
	logic [RW-1:0]            rem_d [4];

	assign accept     = pipe_stb_i && pipe_ack_o;
	assign pipe_ack_o = !running_q && !pipe_stb_o; // Idle only.
	assign steps_done = (step_q == 5'(STEPS));

	// One restoring step for each of the four edges.
	always_comb begin
		logic [RW:0] trial;
		logic [RW:0] sub;
		for (int k = 0; k < 4; k++) begin
			trial = {rem_q[k], dvd_q[k][DW-1]}; // Bring down next bit.
			sub   = trial - {1'b0, ctx_q.dry};
			if (trial >= {1'b0, ctx_q.dry}) begin
				rem_d[k] = sub[RW-1:0];
				dvd_d[k] = {dvd_q[k][DW-2:0], 1'b1};
			end else begin
				rem_d[k] = trial[RW-1:0]; // Top bit is zero, trial < dry.
				dvd_d[k] = {dvd_q[k][DW-2:0], 1'b0};
			end
		end
	end

	// Sequencer.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			running_q  <= 1'b0;
			step_q     <= '0;
			pipe_stb_o <= 1'b0;
		end else if (accept) begin
			running_q <= 1'b1;
			step_q    <= '0;
		end else if (running_q) begin
			if (steps_done) begin
				running_q  <= 1'b0;
				pipe_stb_o <= 1'b1; // Extra cycle after the last step.
			end else begin
				step_q <= step_q + 1'b1;
			end
		end else if (pipe_stb_o && pipe_ack_i) begin
			pipe_stb_o <= 1'b0;
		end
	end

	// Datapath.
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			ctx_q    <= ops_i;
			dvd_q[0] <= ops_i.dcx.mag;
			dvd_q[1] <= ops_i.dcy.mag;
			dvd_q[2] <= ops_i.ddx.mag;
			dvd_q[3] <= ops_i.ddy.mag;
			for (int k = 0; k < 4; k++) begin
				rem_q[k] <= '0;
			end
		end else if (running_q && !steps_done) begin
			for (int k = 0; k < 4; k++) begin
				dvd_q[k] <= dvd_d[k];
				rem_q[k] <= rem_d[k];
			end
		end
	end

	always_comb begin
		div_o.a   = ctx_q.a;
		div_o.b   = ctx_q.b;
		div_o.drx = ctx_q.drx;
		div_o.dry = ctx_q.dry;
		div_o.dcx = '{pos: ctx_q.dcx.pos, quo: dvd_q[0], rem: rem_q[0]};
		div_o.dcy = '{pos: ctx_q.dcy.pos, quo: dvd_q[1], rem: rem_q[1]};
		div_o.ddx = '{pos: ctx_q.ddx.pos, quo: dvd_q[2], rem: rem_q[2]};
		div_o.ddy = '{pos: ctx_q.ddy.pos, quo: dvd_q[3], rem: rem_q[3]};
	end

	// Zero height would make the stepper run forever.
	a_dry_nonzero: assert property (@(posedge sys_clk) disable iff (sys_rst)
		accept |-> (ops_i.dry != '0))
		else $error("tmu_vdiv: quad accepted with dry of zero.");

	// Stepper subtracts dry at most once per line, so remainders must be in range.
	a_rem_range: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_o |-> ((div_o.dcx.rem < div_o.dry) && (div_o.dcy.rem < div_o.dry)
			&& (div_o.ddx.rem < div_o.dry) && (div_o.ddy.rem < div_o.dry)))
		else $error("tmu_vdiv: remainder not below dry.");

endmodule

`default_nettype wire

// File: tmu_vdivops.sv
/*
 * Difference stage. Registers C-A and D-A as magnitude and direction.
 * Differences must fit in DIFF_W bits of magnitude, larger ones wrap.
 * Sustains one quad per cycle, back-pressure holds the output register.
 */
`timescale 1ns/1ps
`default_nettype none

module tmu_vdivops (
	input  wire                           sys_clk,
	input  wire                           sys_rst,

	input  wire                           pipe_stb_i,
	output logic                          pipe_ack_o,
	input  wire tmu_vsetup_pkg::quad_t    quad_i,

	output logic                          pipe_stb_o,
	input  wire                           pipe_ack_i,
	output tmu_vsetup_pkg::diffops_t      ops_o
);

	logic accept;

	// Direction and absolute distance from origin to end point.
	function automatic tmu_vsetup_pkg::delta_t edge_delta(
		input logic signed [tmu_vsetup_pkg::COORD_W-1:0] p_end,
		input logic signed [tmu_vsetup_pkg::COORD_W-1:0] p_org
	);
		tmu_vsetup_pkg::delta_t                     d;
		logic signed [tmu_vsetup_pkg::COORD_W-1:0] diff;
		d.pos = (p_end > p_org); // Signed compare.
		if (d.pos) begin
			diff = p_end - p_org;
		end else begin
			diff = p_org - p_end; // Equal points give zero, flagged negative.
		end
		d.mag = diff[tmu_vsetup_pkg::DIFF_W-1:0];
		return d;
	endfunction

	assign pipe_ack_o = !pipe_stb_o || pipe_ack_i; // Empty or draining.
	assign accept     = pipe_stb_i && pipe_ack_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pipe_stb_o <= 1'b0;
		end else if (pipe_ack_o) begin
			pipe_stb_o <= pipe_stb_i; // Refill, or go empty after handing off.
		end
	end

	// Payload only moves on acceptance.
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			ops_o.a   <= quad_i.a;
			ops_o.b   <= quad_i.b;
			ops_o.drx <= quad_i.drx;
			ops_o.dry <= quad_i.dry;
			ops_o.dcx <= edge_delta(quad_i.c.x, quad_i.a.x);
			ops_o.dcy <= edge_delta(quad_i.c.y, quad_i.a.y);
			ops_o.ddx <= edge_delta(quad_i.d.x, quad_i.a.x);
			ops_o.ddy <= edge_delta(quad_i.d.y, quad_i.a.y);
		end
	end

	// A stalled item must reach the divider unchanged.
	a_hold_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(pipe_stb_o && !pipe_ack_i) |=> (pipe_stb_o && $stable(ops_o)))
		else $error("tmu_vdivops: output changed while stalled.");

endmodule

`default_nettype wire

// File: tmu_vsetup_pkg.sv
/*
 * Widths and stage records of the vertical setup pipeline.
 * Corner coordinates are signed, deltas between corners must fit in DIFF_W bits.
 * Resolutions are unsigned and dry must be nonzero.
 */
`default_nettype none

package tmu_vsetup_pkg;

	localparam int COORD_W = 18; // Signed mesh coordinate.
	localparam int DIFF_W  = 17; // Edge delta magnitude.
	localparam int RES_W   = 12; // Destination width and height.

	// One mesh point.
	typedef struct packed {
		logic signed [COORD_W-1:0] x;
		logic signed [COORD_W-1:0] y;
	} vertex_t;

	// Request entering the pipeline.
	typedef struct packed {
		vertex_t          a;
		vertex_t          b;
		vertex_t          c;
		vertex_t          d;
		logic [RES_W-1:0] drx;
		logic [RES_W-1:0] dry;
	} quad_t;

	// Edge delta as direction plus magnitude.
	typedef struct packed {
		logic              pos; // End point is greater than A.
		logic [DIFF_W-1:0] mag;
	} delta_t;

	// Result of the difference stage.
	typedef struct packed {
		vertex_t          a;
		vertex_t          b;
		logic [RES_W-1:0] drx;
		logic [RES_W-1:0] dry;
		delta_t           dcx; // C minus A.
		delta_t           dcy;
		delta_t           ddx; // D minus A.
		delta_t           ddy;
	} diffops_t;

	// Per-edge division result, mag = quo * dry + rem.
	typedef struct packed {
		logic              pos;
		logic [DIFF_W-1:0] quo;
		logic [RES_W-1:0]  rem;
	} edgediv_t;

	// Result of the divider stage.
	typedef struct packed {
		vertex_t          a;
		vertex_t          b;
		logic [RES_W-1:0] drx;
		logic [RES_W-1:0] dry;
		edgediv_t         dcx;
		edgediv_t         dcy;
		edgediv_t         ddx;
		edgediv_t         ddy;
	} divres_t;

	// One output line of the vertical stepper.
	typedef struct packed {
		logic [RES_W-1:0] idx;   // Line number, 0 to dry-1.
		logic             last;  // Final line of the quad.
		vertex_t          left;  // Point on the A-C edge.
		vertex_t          right; // Point on the A-D edge.
		vertex_t          b;     // Context for the horizontal stage.
		logic [RES_W-1:0] drx;
	} line_t;

endpackage

`default_nettype wire
